// File: l2_sub.f
+incdir+rtl
rtl/l2_types_pkg.sv
rtl/l2_arbiter.sv
rtl/l2_cache.sv
rtl/l2_mem_bridge.sv
rtl/l2_top.sv
tests/l2_mem_model.sv
tests/l2_tb.sv

// File: rtl/l2_arbiter.sv
// Round-robin input arbiter that picks one of two L1 ports and routes the cache response back
`timescale 1ns/1ns

module l2_arbiter (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  l2_types_pkg::l1_req_t [1:0]  i_l1_req,
    output logic [1:0]                   o_l1_ready,
    output l2_types_pkg::l1_resp_t [1:0] o_l1_resp,
    output l2_types_pkg::l1_req_t        o_req,
    input  logic                         i_req_ready,
    input  l2_types_pkg::l1_resp_t       i_resp
);
    import l2_types_pkg::*;

    // Port served most recently, and the port that owns the request in flight
    logic last_port;
    logic owner;
    logic busy;
    logic sel;
    logic take;

    // When both ports wait, the one that was not served last gets the turn
    always_comb begin
        if (i_l1_req[0].valid && i_l1_req[1].valid) begin
            sel = ~last_port;
        end else begin
            sel = i_l1_req[1].valid;
        end
    end

    always_comb begin
        o_l1_ready      = 2'b00;
        o_l1_ready[sel] = !busy && i_l1_req[sel].valid;
    end

    assign take = o_l1_ready[sel];

    // Data goes to both ports, the valid only to the owner
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            o_l1_resp[p]       = i_resp;
            o_l1_resp[p].valid = i_resp.valid && (owner == 1'(p));
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy      <= 1'b0;
            last_port <= 1'b1;
            owner     <= 1'b0;
            o_req     <= '0;
        end else begin
            // Drop the offer once the cache has taken it
            if (o_req.valid && i_req_ready) begin
                o_req.valid <= 1'b0;
            end

            if (take) begin
                o_req     <= i_l1_req[sel];
                busy      <= 1'b1;
                owner     <= sel;
                last_port <= sel;
            end

            // The response closes the transfer and frees the arbiter
            if (i_resp.valid) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/l2_cache.sv
// Direct-mapped write-back L2 cache core; serves hits locally and fills misses through the bridge
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_cache (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  l2_types_pkg::l1_req_t  i_req,
    output logic                   o_req_ready,
    output l2_types_pkg::l1_resp_t o_resp,
    output l2_types_pkg::mem_req_t o_mem_req,
    input  logic                   i_mem_ready,
    input  logic                   i_mem_done,
    input  l2_types_pkg::l2_line_t i_mem_data,
    input  logic                   i_load_fault,
    input  logic                   i_store_fault,
    input  logic                   i_flush_valid,
    output logic                   o_flush_end
);
    import l2_types_pkg::*;

    localparam int NUM_LINES = 1 << `L2_INDEX_BITS;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB,
        ST_FILL,
        ST_RESP,
        ST_FLUSH,
        ST_FLUSH_WB
    } state_e;

    state_e               state;
    l2_line_t             data_mem [NUM_LINES];
    l2_tag_t              tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_bits;
    logic [NUM_LINES-1:0] dirty_bits;
    l1_req_t              req_q;
    logic                 flush_req;
    l2_index_t            flush_idx;
    l2_index_t            in_idx;
    l2_index_t            req_idx;
    logic                 in_hit;
    logic                 take;
    logic                 line_we;
    l2_index_t            line_widx;
    l2_tag_t              line_wtag;
    l2_line_t             line_wdata;

    // Byte-strobe merge of new data over an existing line
    function automatic l2_line_t merge_line(l2_line_t old_line, l2_line_t new_line,
                                            l2_strb_t strb);
        l2_line_t res;
        res = old_line;
        for (int b = 0; b < `L2_LINE_BYTES; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_line[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign in_idx  = i_req.addr.f.index;
    assign req_idx = req_q.addr.f.index;
    assign in_hit  = valid_bits[in_idx] && (tag_mem[in_idx] == i_req.addr.f.tag);

    // A pending flush blocks new requests until the walk has finished
    assign o_req_ready = (state == ST_IDLE) && !flush_req && i_req.valid;
    assign take        = o_req_ready;

    // Single write port into the line storage, used by write hits and by fills
    always_comb begin
        line_we    = 1'b0;
        line_widx  = in_idx;
        line_wtag  = i_req.addr.f.tag;
        line_wdata = merge_line(data_mem[in_idx], i_req.wdata, i_req.wstrb);
        if (take && in_hit && i_req.write) begin
            line_we = 1'b1;
        end else if (state == ST_FILL && i_mem_done && !i_load_fault) begin
            line_we    = 1'b1;
            line_widx  = req_idx;
            line_wtag  = req_q.addr.f.tag;
            line_wdata = req_q.write ? merge_line(i_mem_data, req_q.wdata, req_q.wstrb)
                                     : i_mem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (line_we) begin
            data_mem[line_widx] <= line_wdata;
            tag_mem[line_widx]  <= line_wtag;
        end
        if (take) begin
            req_q <= i_req;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= ST_IDLE;
            valid_bits  <= '0;
            dirty_bits  <= '0;
            flush_req   <= 1'b0;
            flush_idx   <= '0;
            o_resp      <= '0;
            o_mem_req   <= '0;
            o_flush_end <= 1'b0;
        end else begin
            o_resp.valid <= 1'b0;
            o_flush_end  <= 1'b0;
            if (o_mem_req.valid && i_mem_ready) begin
                o_mem_req.valid <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (flush_req) begin
                        flush_req <= 1'b0;
                        flush_idx <= '0;
                        state     <= ST_FLUSH;
                    end else if (take) begin
                        if (in_hit) begin
                            o_resp <= '{valid: 1'b1, status: L2_OKAY,
                                        rdata: i_req.write ? line_wdata : data_mem[in_idx]};
                            if (i_req.write) begin
                                dirty_bits[in_idx] <= 1'b1;
                            end
                        end else if (valid_bits[in_idx] && dirty_bits[in_idx]) begin
                            // Victim is dirty, so it goes to memory before the fill
                            o_mem_req <= '{valid: 1'b1, write: 1'b1,
                                           line_addr: {tag_mem[in_idx], in_idx},
                                           data: data_mem[in_idx]};
                            state     <= ST_WB;
                        end else begin
                            o_mem_req <= '{valid: 1'b1, write: 1'b0, data: '0,
                                           line_addr: i_req.addr.raw[`L2_ADDR_BITS-1:L2_OFFSET_BITS]};
                            state     <= ST_FILL;
                        end
                    end
                end
                ST_WB: begin
                    if (i_mem_done) begin
                        dirty_bits[req_idx] <= 1'b0;
                        if (i_store_fault) begin
                            // Victim could not be saved; drop it and fail the request
                            valid_bits[req_idx] <= 1'b0;
                            o_resp              <= '{valid: 1'b1, rdata: '0, status: L2_ERR};
                            state               <= ST_IDLE;
                        end else begin
                            o_mem_req <= '{valid: 1'b1, write: 1'b0, data: '0,
                                           line_addr: req_q.addr.raw[`L2_ADDR_BITS-1:L2_OFFSET_BITS]};
                            state     <= ST_FILL;
                        end
                    end
                end
                ST_FILL: begin
                    if (i_mem_done) begin
                        if (i_load_fault) begin
                            o_resp <= '{valid: 1'b1, rdata: '0, status: L2_ERR};
                            state  <= ST_IDLE;
                        end else begin
                            valid_bits[req_idx] <= 1'b1;
                            dirty_bits[req_idx] <= req_q.write;
                            state               <= ST_RESP;
                        end
                    end
                end
                ST_RESP: begin
                    o_resp <= '{valid: 1'b1, rdata: data_mem[req_idx], status: L2_OKAY};
                    state  <= ST_IDLE;
                end
                ST_FLUSH: begin
                    if (valid_bits[flush_idx] && dirty_bits[flush_idx]) begin
                        o_mem_req <= '{valid: 1'b1, write: 1'b1,
                                       line_addr: {tag_mem[flush_idx], flush_idx},
                                       data: data_mem[flush_idx]};
                        state     <= ST_FLUSH_WB;
                    end else begin
                        valid_bits[flush_idx] <= 1'b0;
                        dirty_bits[flush_idx] <= 1'b0;
                        flush_idx             <= flush_idx + 1'b1;
                        if (flush_idx == '1) begin
                            o_flush_end <= 1'b1;
                            state       <= ST_IDLE;
                        end
                    end
                end
                ST_FLUSH_WB: begin
                    // A store fault here changes nothing, the line is invalidated anyway
                    if (i_mem_done) begin
                        valid_bits[flush_idx] <= 1'b0;
                        dirty_bits[flush_idx] <= 1'b0;
                        flush_idx             <= flush_idx + 1'b1;
                        if (flush_idx == '1) begin
                            o_flush_end <= 1'b1;
                            state       <= ST_IDLE;
                        end else begin
                            state <= ST_FLUSH;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            // Kept after the FSM so a pulse that lands while a flush starts is not lost
            if (i_flush_valid) begin
                flush_req <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/l2_mem_bridge.sv
// Memory-side bridge that carries one line transfer on the memory bus and sorts its errors
`timescale 1ns/1ns

module l2_mem_bridge (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  l2_types_pkg::mem_req_t  i_req,
    output logic                    o_req_ready,
    output logic                    o_done,
    output l2_types_pkg::l2_line_t  o_data,
    output logic                    o_load_fault,
    output logic                    o_store_fault,
    output l2_types_pkg::mem_req_t  o_mem_req,
    input  logic                    i_mem_ready,
    input  l2_types_pkg::mem_resp_t i_mem_resp
);
    import l2_types_pkg::*;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_REQ,
        BR_RESP
    } br_state_e;

    br_state_e state;
    logic      is_write;

    assign o_req_ready = (state == BR_IDLE) && i_req.valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state         <= BR_IDLE;
            o_mem_req     <= '0;
            o_done        <= 1'b0;
            o_load_fault  <= 1'b0;
            o_store_fault <= 1'b0;
        end else begin
            o_done        <= 1'b0;
            o_load_fault  <= 1'b0;
            o_store_fault <= 1'b0;
            case (state)
                BR_IDLE: begin
                    if (o_req_ready) begin
                        o_mem_req <= i_req;
                        state     <= BR_REQ;
                    end
                end
                BR_REQ: begin
                    // Request stays on the bus until memory takes it
                    if (i_mem_ready) begin
                        o_mem_req.valid <= 1'b0;
                        state           <= BR_RESP;
                    end
                end
                BR_RESP: begin
                    // Memory answers one cycle after it takes the request, at the earliest
                    if (i_mem_resp.valid) begin
                        o_done        <= 1'b1;
                        o_load_fault  <= i_mem_resp.err && !is_write;
                        o_store_fault <= i_mem_resp.err && is_write;
                        state         <= BR_IDLE;
                    end
                end
                default: begin
                    state <= BR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_req_ready) begin
            is_write <= i_req.write;
        end
        if (state == BR_RESP && i_mem_resp.valid) begin
            o_data <= i_mem_resp.data;
        end
    end

endmodule

// File: rtl/l2_settings.svh
// Size settings for the L2 subsystem, included by the type package and by RTL that sizes arrays
`ifndef L2_SETTINGS_SVH
`define L2_SETTINGS_SVH

// Width of a byte address on the L1 side and on the memory side
`define L2_ADDR_BITS 16

// Bytes per cache line; a line is eight times this many bits wide
`define L2_LINE_BYTES 8

// Log2 of the number of direct-mapped lines
`define L2_INDEX_BITS 3

// Top two address bits of the region where memory answers with an error
`define L2_FAULT_TOP 2'b11

`endif

// File: rtl/l2_top.sv
// Top level of the L2 subsystem; connects the input arbiter, the cache core and the memory bridge
`timescale 1ns/1ns

module l2_top (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  l2_types_pkg::l1_req_t [1:0]  i_l1_req,
    output logic [1:0]                   o_l1_ready,
    output l2_types_pkg::l1_resp_t [1:0] o_l1_resp,
    input  logic                         i_flush_valid,
    output logic                         o_flush_end,
    output l2_types_pkg::mem_req_t       o_mem_req,
    input  logic                         i_mem_ready,
    input  l2_types_pkg::mem_resp_t      i_mem_resp
);
    import l2_types_pkg::*;

    // Arbiter to cache
    l1_req_t  arb_req;
    logic     arb_req_ready;
    l1_resp_t cache_resp;

    // Cache to bridge
    mem_req_t cache_mem_req;
    logic     cache_mem_ready;
    logic     mem_done;
    l2_line_t mem_data;
    logic     mem_load_fault;
    logic     mem_store_fault;

    l2_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_l1_req    (i_l1_req),
        .o_l1_ready  (o_l1_ready),
        .o_l1_resp   (o_l1_resp),
        .o_req       (arb_req),
        .i_req_ready (arb_req_ready),
        .i_resp      (cache_resp)
    );

    l2_cache u_cache (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req         (arb_req),
        .o_req_ready   (arb_req_ready),
        .o_resp        (cache_resp),
        .o_mem_req     (cache_mem_req),
        .i_mem_ready   (cache_mem_ready),
        .i_mem_done    (mem_done),
        .i_mem_data    (mem_data),
        .i_load_fault  (mem_load_fault),
        .i_store_fault (mem_store_fault),
        .i_flush_valid (i_flush_valid),
        .o_flush_end   (o_flush_end)
    );

    l2_mem_bridge u_bridge (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req         (cache_mem_req),
        .o_req_ready   (cache_mem_ready),
        .o_done        (mem_done),
        .o_data        (mem_data),
        .o_load_fault  (mem_load_fault),
        .o_store_fault (mem_store_fault),
        .o_mem_req     (o_mem_req),
        .i_mem_ready   (i_mem_ready),
        .i_mem_resp    (i_mem_resp)
    );

endmodule

// File: rtl/l2_types_pkg.sv
// Shared request, response, memory-bus and address types for all L2 subsystem modules
`include "l2_settings.svh"

package l2_types_pkg;

    localparam int unsigned L2_LINE_BITS   = 8 * `L2_LINE_BYTES;
    localparam int unsigned L2_OFFSET_BITS = $clog2(`L2_LINE_BYTES);
    localparam int unsigned L2_TAG_BITS    = `L2_ADDR_BITS - `L2_INDEX_BITS - L2_OFFSET_BITS;

    typedef logic [L2_LINE_BITS-1:0]                  l2_line_t;
    typedef logic [`L2_LINE_BYTES-1:0]                l2_strb_t;
    typedef logic [L2_TAG_BITS-1:0]                   l2_tag_t;
    typedef logic [`L2_INDEX_BITS-1:0]                l2_index_t;
    typedef logic [L2_OFFSET_BITS-1:0]                l2_offset_t;
    typedef logic [`L2_ADDR_BITS-L2_OFFSET_BITS-1:0]  l2_line_addr_t;

    typedef struct packed {
        l2_tag_t    tag;
        l2_index_t  index;
        l2_offset_t offset;
    } l2_addr_fields_t;

    // The same address word seen flat or split into cache fields
    typedef union packed {
        logic [`L2_ADDR_BITS-1:0] raw;
        l2_addr_fields_t          f;
    } l2_addr_u;

    typedef struct packed {
        logic     valid;
        logic     write;
        l2_addr_u addr;
        l2_line_t wdata;
        l2_strb_t wstrb;
    } l1_req_t;

    typedef enum logic [1:0] {
        L2_OKAY = 2'b00,
        L2_ERR  = 2'b10
    } l2_status_e;

    typedef struct packed {
        logic       valid;
        l2_line_t   rdata;
        l2_status_e status;
    } l1_resp_t;

    typedef struct packed {
        logic          valid;
        logic          write;
        l2_line_addr_t line_addr;
        l2_line_t      data;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        l2_line_t data;
        logic     err;
    } mem_resp_t;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f l2_sub.f --top-module l2_tb -o l2_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/l2_sim | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

// File: tests/l2_mem_model.sv
// Line-level memory model for the testbench; answers the L2 memory bus with stalls and faults
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_mem_model (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic [1:0]              i_stall,
    input  l2_types_pkg::mem_req_t  i_mem_req,
    output logic                    o_mem_ready,
    output l2_types_pkg::mem_resp_t o_mem_resp
);
    import l2_types_pkg::*;

    localparam int LINES = 1 << $bits(l2_line_addr_t);

    l2_line_t lines [LINES];
    mem_req_t req_q;
    logic     pending;

    // Fill pattern built from every bit of the line address
    function automatic l2_line_t fill_line(int a);
        return {16'(a), 16'(~a), 16'(a * 5), 16'(a ^ 32'h5a5a)};
    endfunction

    // The top address bits select the region that answers with an error
    function automatic logic in_fault(l2_line_addr_t la);
        return la[$bits(l2_line_addr_t)-1 -: 2] == `L2_FAULT_TOP;
    endfunction

    // Stall bit 0 holds ready low, stall bit 1 delays the response
    assign o_mem_ready = !pending && !i_stall[0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < LINES; i++) begin
                lines[l2_line_addr_t'(i)] <= fill_line(i);
            end
            pending    <= 1'b0;
            req_q      <= '0;
            o_mem_resp <= '0;
        end else begin
            o_mem_resp.valid <= 1'b0;
            if (i_mem_req.valid && o_mem_ready) begin
                pending <= 1'b1;
                req_q   <= i_mem_req;
                // Writes outside the fault region land in the array right away
                if (i_mem_req.write && !in_fault(i_mem_req.line_addr)) begin
                    lines[i_mem_req.line_addr] <= i_mem_req.data;
                end
            end else if (pending && !i_stall[1]) begin
                pending    <= 1'b0;
                o_mem_resp <= '{valid: 1'b1, data: lines[req_q.line_addr],
                                err: in_fault(req_q.line_addr)};
            end
        end
    end

endmodule

// File: tests/l2_tb.sv
// Testbench for the L2 subsystem; drives both L1 ports and checks responses against a shadow memory
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_tb;
    import l2_types_pkg::*;

    localparam int CLK_HALF = 5;
    localparam int TIMEOUT  = 400;
    localparam int LINES    = 1 << $bits(l2_line_addr_t);

    logic           clk = 1'b0;
    logic           rst;
    l1_req_t [1:0]  l1_req;
    logic [1:0]     l1_ready;
    l1_resp_t [1:0] l1_resp;
    logic           flush_valid;
    logic           flush_end;
    mem_req_t       mem_req;
    logic           mem_ready;
    mem_resp_t      mem_resp;
    logic [1:0]     mem_stall = 2'b00;

    logic [31:0] data_lfsr  = 32'h3389;
    logic [31:0] stall_lfsr = 32'h3389;

    // Expected line contents, updated only from the testbench's own writes
    l2_line_t shadow [LINES];
    bit       written [LINES];

    // Requests taken and responses seen on each port
    int taken_cnt [2];
    int resp_cnt [2];

    string cur_test;
    int    errors_at_start;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    checks       = 0;
    int    errors       = 0;

    l2_top u_l2_top (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_l1_req      (l1_req),
        .o_l1_ready    (l1_ready),
        .o_l1_resp     (l1_resp),
        .i_flush_valid (flush_valid),
        .o_flush_end   (flush_end),
        .o_mem_req     (mem_req),
        .i_mem_ready   (mem_ready),
        .i_mem_resp    (mem_resp)
    );

    l2_mem_model u_mem (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_stall     (mem_stall),
        .i_mem_req   (mem_req),
        .o_mem_ready (mem_ready),
        .o_mem_resp  (mem_resp)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_data(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            v         = {v[62:0], data_lfsr[0]};
        end
        return v;
    endfunction

    function automatic l2_line_t apply_strobes(l2_line_t old_line, l2_line_t new_line,
                                               l2_strb_t strb);
        l2_line_t mask;
        for (int b = 0; b < `L2_LINE_BYTES; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return (old_line & ~mask) | (new_line & mask);
    endfunction

    function automatic l2_line_addr_t line_of(logic [`L2_ADDR_BITS-1:0] addr);
        return addr[`L2_ADDR_BITS-1:L2_OFFSET_BITS];
    endfunction

    // Random memory stalls, two fresh bits every cycle
    always @(negedge clk) begin
        stall_lfsr   = lfsr_next(stall_lfsr);
        mem_stall[0] = stall_lfsr[0];
        stall_lfsr   = lfsr_next(stall_lfsr);
        mem_stall[1] = stall_lfsr[0];
    end

    // A response may only reach a port that has a request taken and not yet answered
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < 2; p++) begin
                if (l1_resp[p].valid) begin
                    assert (resp_cnt[p] < taken_cnt[p]) else begin
                        $display("Port %0d got a response it did not ask for in test %s",
                                 p, cur_test);
                        errors++;
                    end
                    resp_cnt[p]++;
                end
            end
        end
    end

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("Test %s: failed", cur_test);
        end else begin
            $display("Test %s: passed", cur_test);
        end
    endtask

    task automatic do_request(input logic p, input logic wr, input logic [`L2_ADDR_BITS-1:0] addr,
                              input l2_line_t wdata, input l2_strb_t wstrb,
                              output l2_line_t rdata, output l2_status_e status, output bit ok);
        l1_req_t req;
        bit      taken;
        int      cycles;
        req          = '0;
        req.valid    = 1'b1;
        req.write    = wr;
        req.addr.raw = addr;
        req.wdata    = wdata;
        req.wstrb    = wstrb;
        rdata        = '0;
        status       = L2_OKAY;
        ok           = 1'b0;
        taken        = 1'b0;
        cycles       = 0;
        @(negedge clk);
        l1_req[p] = req;
        // Ready is looked at just before the rising edge, when all falling-edge drives have settled
        while (!taken && cycles < TIMEOUT) begin
            #(CLK_HALF - 1);
            taken = l1_ready[p];
            @(negedge clk);
            cycles++;
        end
        l1_req[p] = '0;
        if (!taken) begin
            $display("Port %0d request to %h was never accepted in test %s", p, addr, cur_test);
            errors++;
            return;
        end
        taken_cnt[p]++;
        cycles = 0;
        while (!l1_resp[p].valid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!l1_resp[p].valid) begin
            $display("Port %0d got no response for %h in test %s", p, addr, cur_test);
            errors++;
            return;
        end
        rdata  = l1_resp[p].rdata;
        status = l1_resp[p].status;
        ok     = 1'b1;
    endtask

    task automatic write_line(input logic p, input logic [`L2_ADDR_BITS-1:0] addr,
                              input l2_line_t data, input l2_strb_t strb);
        l2_line_addr_t la;
        l2_line_t      exp;
        l2_line_t      rdata;
        l2_status_e    st;
        bit            ok;
        la  = line_of(addr);
        exp = apply_strobes(shadow[la], data, strb);
        do_request(p, 1'b1, addr, data, strb, rdata, st, ok);
        shadow[la]  = exp;
        written[la] = 1'b1;
        if (ok) begin
            check_value("write status", 64'(L2_OKAY), 64'(st));
            check_value("write data", exp, rdata);
        end
    endtask

    task automatic read_line(input logic p, input logic [`L2_ADDR_BITS-1:0] addr);
        l2_line_t   rdata;
        l2_status_e st;
        bit         ok;
        do_request(p, 1'b0, addr, '0, '0, rdata, st, ok);
        if (ok) begin
            check_value("read status", 64'(L2_OKAY), 64'(st));
            check_value("read data", shadow[line_of(addr)], rdata);
        end
    endtask

    task automatic flush_cache();
        int cycles;
        cycles = 0;
        @(negedge clk);
        flush_valid = 1'b1;
        @(negedge clk);
        flush_valid = 1'b0;
        while (!flush_end && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!flush_end) begin
            $display("Flush did not end within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    initial begin : stimulus
        l2_line_t   d0;
        l2_line_t   d1;
        l2_line_t   rdata;
        l2_status_e st;
        bit         ok;
        l1_req      = '0;
        flush_valid = 1'b0;
        rst         = 1'b1;
        cur_test    = "reset";
        repeat (3) @(negedge clk);
        rst = 1'b0;

        start_test("read_after_write");
        write_line(1'b0, 16'h0010, rand_data(64), 8'hff);
        read_line(1'b0, 16'h0010);
        finish_test();

        start_test("strobe_merge");
        d0 = rand_data(64);
        write_line(1'b0, 16'h0010, d0, 8'(rand_data(8)));
        read_line(1'b0, 16'h0010);
        finish_test();

        // Same index, different tags
        start_test("eviction");
        write_line(1'b1, 16'h0108, rand_data(64), 8'hff);
        write_line(1'b1, 16'h0508, rand_data(64), 8'hff);
        read_line(1'b1, 16'h0108);
        finish_test();

        start_test("two_ports");
        d0 = rand_data(64);
        d1 = rand_data(64);
        fork
            write_line(1'b0, 16'h0218, d0, 8'hff);
            write_line(1'b1, 16'h0420, d1, 8'hff);
        join
        fork
            read_line(1'b0, 16'h0218);
            read_line(1'b1, 16'h0420);
        join
        finish_test();

        start_test("fault");
        do_request(1'b0, 1'b0, {`L2_FAULT_TOP, 14'h0028}, '0, '0, rdata, st, ok);
        if (ok) begin
            check_value("read status", 64'(L2_ERR), 64'(st));
        end
        do_request(1'b1, 1'b1, {`L2_FAULT_TOP, 14'h0030}, rand_data(64), 8'hff, rdata, st, ok);
        if (ok) begin
            check_value("write status", 64'(L2_ERR), 64'(st));
        end
        finish_test();

        start_test("flush");
        write_line(1'b0, 16'h0038, rand_data(64), 8'hff);
        write_line(1'b1, 16'h0800, rand_data(64), 8'hff);
        write_line(1'b0, 16'h0218, rand_data(64), 8'h3c);
        flush_cache();
        for (int i = 0; i < LINES; i++) begin
            if (written[i]) begin
                check_value($sformatf("memory line %h", i), shadow[i],
                            u_mem.lines[l2_line_addr_t'(i)]);
            end
        end
        finish_test();

        $display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
